/* src/lau_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, enums and stage structs for the
// difference unit, imported by every RTL module
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package lau_pkg;

	localparam int LAU_WIDTH = 16; // operand width

	typedef logic [LAU_WIDTH-1:0] word_t; // operands and results
	typedef logic [LAU_WIDTH:0]   wide_t; // difference with borrow on top

	// prefix network choice
	typedef enum logic [1:0] {
		SLOW   = 2'b00,
		MEDIUM = 2'b01,
		FAST   = 2'b10
	} speed_e;

	localparam speed_e LAU_SPEED = FAST;

	typedef enum logic [2:0] {
		OP_SUB     = 3'd0, // a - b, also taken for unused codes
		OP_RSUB    = 3'd1, // b - a
		OP_ABSDIFF = 3'd2,
		OP_MIN     = 3'd3,
		OP_MAX     = 3'd4
	} op_e;

	// result source in execute
	typedef enum logic [1:0] {
		SEL_AB = 2'd0,
		SEL_BA = 2'd1,
		SEL_A  = 2'd2,
		SEL_B  = 2'd3
	} sel_e;

	typedef struct packed {
		op_e   op;
		word_t a;
		word_t b;
	} op_req_t; // 35 bits

	typedef struct packed {
		sel_e  sel;
		logic  by_borrow; // swap source when a < b
		word_t a;
		word_t b;
	} exe_ctrl_t;

	typedef struct packed {
		word_t result;
		logic  borrow; // a < b, unsigned
		logic  zero;   // a == b
	} lau_res_t; // 18 bits

	// floor(log2(n)), -1 for n == 0
	function automatic int log2floor(input int n);
		int m;
		int p;
		m = -1;
		p = 1;
		while (p <= n) begin
			m = m + 1;
			p = p * 2;
		end
		return m;
	endfunction

endpackage

`default_nettype wire

/* src/prefix_and_or.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// parallel-prefix and-or network for carry lookahead
// speed picks serial, Brent-Kung or Sklansky
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module prefix_and_or
	import lau_pkg::*;
#(
	parameter int     width = 8,         // word width
	parameter speed_e speed = LAU_SPEED  // network structure
) (
	input  logic [width-1:0] gi, // generate in
	input  logic [width-1:0] pi, // propagate in
	output logic [width-1:0] go, // group generate out
	output logic [width-1:0] po  // group propagate out
);

	localparam int n = width;
	localparam int m = log2floor(width - 1) + 1; // ceil(log2(width)) levels of depth

	if (speed == FAST) begin : g_sklansky
		// m levels where each bit passes or joins its left half
		logic [(m+1)*n-1:0] gt, pt;

		assign gt[n-1:0] = gi;
		assign pt[n-1:0] = pi;

		for (genvar l = 1; l <= m; l++) begin : g_lvl
			localparam int cur  = l * n;
			localparam int prv  = (l - 1) * n;
			localparam int half = 2**(l-1);
			for (genvar j = 0; j < n; j++) begin : g_bit
				if ((j / half) % 2 == 1) begin : g_node
					// last bit of the lower half of this group
					localparam int src = (j / (2*half)) * (2*half) + half - 1;
					assign gt[cur+j] = gt[prv+j] | (pt[prv+j] & gt[prv+src]);
					assign pt[cur+j] = pt[prv+j] & pt[prv+src];
				end else begin : g_pass
					assign gt[cur+j] = gt[prv+j];
					assign pt[cur+j] = pt[prv+j];
				end
			end
		end

		assign go = gt[(m+1)*n-1 : m*n];
		assign po = pt[(m+1)*n-1 : m*n];
	end else if (speed == MEDIUM) begin : g_brent_kung
		logic [2*m*n-1:0] gt, pt; // up tree then down tree

		assign gt[n-1:0] = gi;
		assign pt[n-1:0] = pi;

		// up sweep with one node at the top of each group
		for (genvar l = 1; l <= m; l++) begin : g_up
			localparam int cur = l * n;
			localparam int prv = (l - 1) * n;
			for (genvar k = 0; k < 2**(m-l); k++) begin : g_grp
				localparam int hi = k * 2**l + 2**l - 1;     // group top
				localparam int lo = k * 2**l + 2**(l-1) - 1; // lower half top
				for (genvar i = 0; i < 2**l - 1; i++) begin : g_bit
					if (k * 2**l + i < n) begin : g_pass
						assign gt[cur+k*2**l+i] = gt[prv+k*2**l+i];
						assign pt[cur+k*2**l+i] = pt[prv+k*2**l+i];
					end
				end
				if (hi < n) begin : g_node
					assign gt[cur+hi] = gt[prv+hi] | (pt[prv+hi] & gt[prv+lo]);
					assign pt[cur+hi] = pt[prv+hi] & pt[prv+lo];
				end
			end
		end

		// down sweep fills the middle of each span
		for (genvar l = m + 1; l < 2*m; l++) begin : g_down
			localparam int cur  = l * n;
			localparam int prv  = (l - 1) * n;
			localparam int span = 2**(2*m-l);
			localparam int half = span / 2;
			for (genvar i = 0; i < span; i++) begin : g_head
				if (i < n) begin : g_pass
					assign gt[cur+i] = gt[prv+i];
					assign pt[cur+i] = pt[prv+i];
				end
			end
			for (genvar k = 1; k < 2**(l-m); k++) begin : g_grp
				localparam int base = k * span;
				for (genvar i = 0; i < span; i++) begin : g_bit
					if (base + i < n && i == half - 1) begin : g_node
						assign gt[cur+base+i] = gt[prv+base+i]
							| (pt[prv+base+i] & gt[prv+base-1]); // join prefix below span
						assign pt[cur+base+i] = pt[prv+base+i] & pt[prv+base-1];
					end else if (base + i < n) begin : g_pass
						assign gt[cur+base+i] = gt[prv+base+i];
						assign pt[cur+base+i] = pt[prv+base+i];
					end
				end
			end
		end

		assign go = gt[2*m*n-1 : (2*m-1)*n];
		assign po = pt[2*m*n-1 : (2*m-1)*n];
	end else begin : g_serial
		// ripple chain is smallest and slowest
		logic [n-1:0] gt, pt;

		assign gt[0] = gi[0];
		assign pt[0] = pi[0];
		for (genvar i = 1; i < n; i++) begin : g_bit
			assign gt[i] = gi[i] | (pi[i] & gt[i-1]);
			assign pt[i] = pi[i] & pt[i-1];
		end

		assign go = gt;
		assign po = pt;
	end

endmodule

`default_nettype wire

/* src/prefix_sub.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// carry-lookahead subtractor, s = a - b
// width must be at least 2
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module prefix_sub
	import lau_pkg::*;
#(
	parameter int     width = 8,
	parameter speed_e speed = LAU_SPEED
) (
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	output logic [width-1:0] s // wraps modulo 2**width
);

	logic [width-1:0] bn;     // b inverted
	logic [width-1:0] gi, pi; // per-bit generate / propagate
	logic [width-1:0] go;     // carry into the next bit
	logic [width-1:0] ht;     // half sum a ^ ~b

	assign bn = ~b;

	// bit 0 absorbs the +1 of two's complement
	assign gi[0] = a[0] | bn[0];
	assign pi[0] = 1'b0;
	assign ht[0] = a[0] ^ bn[0];

	for (genvar i = 1; i < width; i++) begin : g_pre
		assign gi[i] = a[i] & bn[i];
		assign pi[i] = a[i] | bn[i];
		assign ht[i] = ~gi[i] & pi[i]; // xor from g and p
	end

	prefix_and_or #(
		.width(width),
		.speed(speed)
	) u_prefix (
		.gi(gi),
		.pi(pi),
		.go(go),
		.po() // group propagate not needed here
	);

	assign s = ht ^ {go[width-2:0], 1'b1}; // carry in of bit 0 is 1

endmodule

`default_nettype wire

/* src/lau_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage, latches a request on in_valid
// and maps the opcode to execute controls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module lau_decode
	import lau_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_valid, // one-cycle strobe
	input  op_req_t   in_req,
	output logic      d_valid,
	output exe_ctrl_t d_ctrl
);

	exe_ctrl_t ctrl_next;

	always_comb begin
		ctrl_next.a         = in_req.a;
		ctrl_next.b         = in_req.b;
		ctrl_next.by_borrow = 1'b0;
		case (in_req.op)
			OP_RSUB: ctrl_next.sel = SEL_BA;
			OP_ABSDIFF: begin
				ctrl_next.sel       = SEL_AB; // becomes b - a when a < b
				ctrl_next.by_borrow = 1'b1;
			end
			// min starts from b, swapped to a when a < b
			OP_MIN: begin
				ctrl_next.sel       = SEL_B;
				ctrl_next.by_borrow = 1'b1;
			end
			OP_MAX: begin
				ctrl_next.sel       = SEL_A; // swapped to b when a < b
				ctrl_next.by_borrow = 1'b1;
			end
			default: ctrl_next.sel = SEL_AB; // OP_SUB and unused codes
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			d_valid <= 1'b0;
			d_ctrl  <= '0;
		end else begin
			d_valid <= in_valid;
			if (in_valid)
				d_ctrl <= ctrl_next; // hold between strobes
		end
	end

endmodule

`default_nettype wire

/* src/lau_execute.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage, purely combinational
// both differences, flags and result mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module lau_execute
	import lau_pkg::*;
#(
	parameter speed_e speed = LAU_SPEED
) (
	input  exe_ctrl_t d_ctrl,
	output lau_res_t  x_res
);

	wide_t diff_ab; // a - b, top bit is borrow
	wide_t diff_ba; // b - a
	logic  borrow;
	sel_e  sel;     // source after the borrow swap

	// one extra bit so the top of the difference is the borrow
	prefix_sub #(
		.width(LAU_WIDTH + 1),
		.speed(speed)
	) u_sub_ab (
		.a({1'b0, d_ctrl.a}),
		.b({1'b0, d_ctrl.b}),
		.s(diff_ab)
	);

	prefix_sub #(
		.width(LAU_WIDTH + 1),
		.speed(speed)
	) u_sub_ba (
		.a({1'b0, d_ctrl.b}),
		.b({1'b0, d_ctrl.a}),
		.s(diff_ba)
	);

	assign borrow = diff_ab[LAU_WIDTH];

	always_comb begin
		sel = d_ctrl.sel;
		if (d_ctrl.by_borrow && borrow) begin
			case (d_ctrl.sel)
				SEL_AB:  sel = SEL_BA; // absdiff
				SEL_A:   sel = SEL_B;
				SEL_B:   sel = SEL_A;
				default: sel = d_ctrl.sel;
			endcase
		end
	end

	always_comb begin
		x_res.borrow = borrow;
		x_res.zero   = ~|diff_ab[LAU_WIDTH-1:0]; // a == b
		case (sel)
			SEL_BA:  x_res.result = diff_ba[LAU_WIDTH-1:0];
			SEL_A:   x_res.result = d_ctrl.a;
			SEL_B:   x_res.result = d_ctrl.b;
			default: x_res.result = diff_ab[LAU_WIDTH-1:0];
		endcase
	end

endmodule

`default_nettype wire

/* src/lau_result.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result stage, registers execute output
// and raises out_valid for one cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module lau_result
	import lau_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     d_valid, // decode strobe, skips execute
	input  lau_res_t x_res,
	output logic     out_valid,
	output lau_res_t out_res
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_res   <= '0;
		end else begin
			out_valid <= d_valid; // pulse, no stall
			if (d_valid)
				out_res <= x_res;
			// else keep last result on the bus
		end
	end

endmodule

`default_nettype wire

/* src/lau_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// difference unit top, decode -> execute -> result
// fixed 2 cycle latency, one op per cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module lau_top
	import lau_pkg::*;
#(
	parameter speed_e speed = LAU_SPEED // prefix network in execute
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  op_req_t  in_req,
	output logic     out_valid,
	output lau_res_t out_res
);

	logic      d_valid; // decode to result
	exe_ctrl_t d_ctrl;  // decode to execute
	lau_res_t  x_res;   // execute to result

	lau_decode u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_req(in_req),
		.d_valid(d_valid),
		.d_ctrl(d_ctrl)
	);

	lau_execute #(
		.speed(speed)
	) u_execute (
		.d_ctrl(d_ctrl),
		.x_res(x_res)
	);

	lau_result u_result (
		.clk(clk),
		.rst_n(rst_n),
		.d_valid(d_valid),
		.x_res(x_res),
		.out_valid(out_valid),
		.out_res(out_res)
	);

endmodule

`default_nettype wire

/* verification/lau_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// watches requests and results of the difference unit,
// checks value and 2 cycle latency, prints one line per test
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module lau_checker
	import lau_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  op_req_t  in_req,
	input  logic     out_valid,
	input  lau_res_t out_res,
	input  int       test_id,   // 0 while in reset
	input  logic     test_done, // one-cycle pulse closing a test
	output int       pending,   // requests without a result yet
	output int       checks,
	output int       errors,
	output int       tests
);

	op_req_t req_q[$];        // outstanding requests with the oldest first
	int      cyc_q[$];        // cycle each request was seen
	int      cycle       = 0;
	int      n_pend      = 0;
	int      n_chk       = 0;
	int      n_err       = 0;
	int      n_tests     = 0;
	int      test_checks = 0;
	int      test_errors = 0;

	assign pending = n_pend;
	assign checks  = n_chk;
	assign errors  = n_err;
	assign tests   = n_tests;

	function automatic string test_name(input int id);
		case (id)
			1: return "sub_rsub";
			2: return "absdiff";
			3: return "min_max";
			4: return "back_to_back";
			5: return "idle_undefined_op";
			default: return "reset";
		endcase
	endfunction

	// expected result from plain integer math mod 2**16
	function automatic lau_res_t expected_result(input op_e op, input word_t a, input word_t b);
		lau_res_t r;
		int ai;
		int bi;
		int d;
		ai = int'(a); // zero extended
		bi = int'(b);
		r.borrow = (ai < bi);
		r.zero   = (ai == bi);
		case (op)
			OP_RSUB:    d = bi - ai;
			OP_ABSDIFF: d = (ai < bi) ? bi - ai : ai - bi;
			OP_MIN:     d = (ai < bi) ? ai : bi;
			OP_MAX:     d = (ai < bi) ? bi : ai;
			default:    d = ai - bi; // sub and the unused codes
		endcase
		if (d < 0)
			d = d + 65536; // wrap
		r.result = word_t'(d);
		return r;
	endfunction

	always @(posedge clk)
		cycle <= cycle + 1;

	// sample mid cycle where inputs and outputs are settled
	always @(negedge clk) begin
		op_req_t  req;
		lau_res_t exp_res;
		int       stamp;
		if (!rst_n) begin
			if (out_valid) begin
				$display("out_valid is high while reset is asserted");
				n_err++;
			end
		end else begin
			if (in_valid) begin
				req_q.push_back(in_req);
				cyc_q.push_back(cycle);
			end
			if (out_valid && req_q.size() == 0) begin
				$display("%s: out_valid arrived with no request outstanding", test_name(test_id));
				n_err++;
				test_errors++;
			end else if (out_valid) begin
				req     = req_q.pop_front();
				stamp   = cyc_q.pop_front();
				exp_res = expected_result(req.op, req.a, req.b);
				n_chk++;
				test_checks++;
				if (out_res !== exp_res) begin
					$display("** Error %s: op %0d a %h b %h expected %h/%b/%b actual %h/%b/%b",
						test_name(test_id), req.op, req.a, req.b,
						exp_res.result, exp_res.borrow, exp_res.zero,
						out_res.result, out_res.borrow, out_res.zero);
					n_err++;
					test_errors++;
				end
				if (cycle - stamp != 2) begin
					$display("%s: result came %0d cycles after its request instead of 2",
						test_name(test_id), cycle - stamp);
					n_err++;
					test_errors++;
				end
			end
			if (test_done) begin
				if (req_q.size() != 0) begin
					$display("%s: %0d requests never got a result", test_name(test_id),
						req_q.size());
					n_err++;
					test_errors++;
					req_q.delete();
					cyc_q.delete();
				end
				$display("test %s: %0d checks, %0d errors", test_name(test_id), test_checks,
					test_errors);
				n_tests++;
				test_checks = 0;
				test_errors = 0;
			end
		end
		n_pend = req_q.size();
	end

endmodule

`default_nettype wire

/* verification/tb_lau.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for lau_top, drives five tests
// and leaves the comparing to lau_checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_lau
	import lau_pkg::*;
();

	localparam int clk_period  = 100;
	localparam int rst_cycles  = 8;
	localparam int idle_cycles = 10;
	localparam int drain_max   = 4; // cycles allowed for the pipe to empty
	localparam int n_tests     = 5;
	localparam int n_ops       = 12 + 8 + 40 + 200 + 12;
	// ops + per test overhead + reset and idle + margin
	localparam int wd_cycles   = n_ops + n_tests * (drain_max + 3) + rst_cycles + idle_cycles + 20;

	logic     clk;
	logic     rst_n;
	logic     in_valid;
	op_req_t  in_req;
	logic     out_valid;
	lau_res_t out_res;
	int       test_id;
	logic     test_done;
	int       pending;
	int       checks;
	int       errors;
	int       tests;
	int       seed;
	int       k;
	word_t    ra;
	word_t    rb;

	lau_top uut (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_req(in_req),
		.out_valid(out_valid),
		.out_res(out_res)
	);

	lau_checker chk (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_req(in_req),
		.out_valid(out_valid),
		.out_res(out_res),
		.test_id(test_id),
		.test_done(test_done),
		.pending(pending),
		.checks(checks),
		.errors(errors),
		.tests(tests)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// one strobe, 5 ns after the edge
	task automatic drive_op(input op_e op, input word_t a, input word_t b);
		@(posedge clk);
		#5;
		in_valid = 1'b1;
		in_req   = '{op, a, b};
	endtask

	task automatic sub_pair(input word_t a, input word_t b);
		drive_op(OP_SUB, a, b);
		drive_op(OP_RSUB, a, b);
	endtask

	task automatic abs_pair(input word_t a, input word_t b);
		drive_op(OP_ABSDIFF, a, b);
		drive_op(OP_ABSDIFF, b, a); // other order
	endtask

	// drop the strobe, wait for results, then close the test
	task automatic end_test();
		int n;
		n = 0;
		@(posedge clk);
		#5;
		in_valid = 1'b0;
		in_req   = '0;
		while (pending != 0 && n < drain_max) begin
			@(posedge clk);
			n++;
		end
		@(posedge clk);
		#5;
		test_done = 1'b1;
		@(posedge clk);
		#5;
		test_done = 1'b0;
	endtask

	// watchdog
	initial begin
		#(wd_cycles * clk_period);
		$display("timeout, run did not finish within %0d cycles", wd_cycles);
		$display("Verification failed");
		$finish;
	end

	initial begin
		seed      = 11;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_req    = '0;
		test_id   = 0;
		test_done = 1'b0;
		repeat (rst_cycles) @(posedge clk);
		#5;
		rst_n = 1'b1;

		test_id = 1; // edges and equal operands
		sub_pair(16'h0000, 16'h0000);
		sub_pair(16'h0000, 16'hffff);
		sub_pair(16'hffff, 16'h0000);
		sub_pair(16'hffff, 16'hffff);
		sub_pair(16'h1234, 16'h1234);
		sub_pair(16'h0001, 16'h8000);
		end_test();

		test_id = 2;
		abs_pair(16'h0000, 16'hffff);
		abs_pair(16'h1234, 16'h00ff);
		abs_pair(16'h8000, 16'h7fff);
		abs_pair(16'h5a5a, 16'h5a5a);
		end_test();

		test_id = 3;
		for (int i = 0; i < 20; i++) begin
			ra = word_t'($random(seed));
			rb = (i % 4 == 0) ? ra : word_t'($random(seed)); // every 4th pair equal
			drive_op(OP_MIN, ra, rb);
			drive_op(OP_MAX, ra, rb);
		end
		end_test();

		test_id = 4; // one strobe every cycle
		for (int i = 0; i < 200; i++) begin
			k  = $unsigned($random(seed)) % 5;
			ra = word_t'($random(seed));
			rb = word_t'($random(seed));
			drive_op(op_e'(k[2:0]), ra, rb);
		end
		end_test();

		test_id = 5;
		repeat (idle_cycles) @(posedge clk); // out_valid must stay low
		for (int c = 5; c < 8; c++) begin
			for (int i = 0; i < 4; i++) begin
				ra = word_t'($random(seed));
				rb = word_t'($random(seed));
				drive_op(op_e'(c[2:0]), ra, rb);
			end
		end
		end_test();

		@(posedge clk);
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0 && tests == n_tests && checks == n_ops) begin
			$display("Verification passed");
		end else begin
			if (errors == 0)
				$display("only %0d of %0d operations were checked", checks, n_ops);
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
src/lau_pkg.sv
src/prefix_and_or.sv
src/prefix_sub.sv
src/lau_decode.sv
src/lau_execute.sv
src/lau_result.sv
src/lau_top.sv
verification/lau_checker.sv
verification/tb_lau.sv

/* Makefile */
TOOL   = verilator
FLAGS  = --binary --timing
TOP    = tb_lau
FLIST  = all.f
OBJDIR = obj_dir
LOG    = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
